//--- Bender.yml
package:
  name: arm_pipeline

export_include_dirs:
  - include

sources:
  - files:
      - hw/arm_pkg.sv
      - hw/instr_buffer.sv
      - hw/register_file.sv
      - hw/decode_stage.sv
      - hw/execute_stage.sv
      - hw/memory_stage.sv
      - hw/arm_pipeline.sv
  - target: simulation
    files:
      - dv/wb_checker.sv
      - dv/tb_arm_pipeline.sv

//--- dv/tb_arm_pipeline.sv
`include "arm_settings.svh"

module tb_arm_pipeline;

    localparam int TIMEOUT = 100;   // Cycles allowed for any single wait
    localparam int AL      = 'hE;

    // Data processing opcodes, bits 24:21
    localparam int OP_AND = 'h0;
    localparam int OP_EOR = 'h1;
    localparam int OP_SUB = 'h2;
    localparam int OP_RSB = 'h3;
    localparam int OP_ADD = 'h4;
    localparam int OP_CMP = 'hA;
    localparam int OP_ORR = 'hC;
    localparam int OP_MOV = 'hD;
    localparam int OP_BIC = 'hE;
    localparam int OP_MVN = 'hF;

    logic            clk;
    logic            rst;
    logic            instr_valid;
    logic            credit;
    arm_pkg::instr_t instr;
    arm_pkg::wb_t    wb;

    string           names [$];
    arm_pkg::instr_t instrs [$];
    arm_pkg::wb_t    expects [$];   // valid clear for rows with no write
    logic            no_gap [$];    // Row goes straight after the one before
    logic            no_gap_now;
    int              credits;       // Sender side
    logic [31:0]     lcg_state;
    logic            aborted;

    arm_pipeline DUT (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .credit      (credit),
        .wb          (wb)
    );

    wb_checker wb_check (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .credit      (credit),
        .wb          (wb)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic arm_pkg::instr_t dp_imm(input int cond, input int op, input int s,
                                               input int rn, input int rd, input int imm8);
        return {cond[3:0], 3'b001, op[3:0], s[0], rn[3:0], rd[3:0], 4'h0, imm8[7:0]};
    endfunction

    function automatic arm_pkg::instr_t dp_reg(input int cond, input int op, input int s,
                                               input int rn, input int rd, input int rm);
        return {cond[3:0], 3'b000, op[3:0], s[0], rn[3:0], rd[3:0], 8'h00, rm[3:0]};
    endfunction

    // Pre-indexed word access, no write-back
    function automatic arm_pkg::instr_t ldst(input int load, input int up, input int rn,
                                             input int rd, input int off12);
        return {4'hE, 3'b010, 1'b1, up[0], 1'b0, 1'b0, load[0], rn[3:0], rd[3:0], off12[11:0]};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_row(input string name, input arm_pkg::instr_t ins, input int writes,
                           input int rd, input arm_pkg::word_t data);
        arm_pkg::wb_t exp;
        exp.valid = writes[0];
        exp.rd    = rd[3:0];
        exp.data  = data;
        names.push_back(name);
        instrs.push_back(ins);
        expects.push_back(exp);
        no_gap.push_back(no_gap_now);
    endtask

    // One rising edge, credit counted as it stood before the edge
    task automatic next_edge();
        @(posedge clk);
        if (credit === 1'b1)
            credits++;
        if (credits > `ARM_BUF_DEPTH)
            wb_check.report_error($sformatf("sender holds %0d credits", credits));
        instr_valid <= 1'b0;
    endtask

    task automatic send_all();
        int gap;
        int waited;
        for (int i = 0; i < names.size() && !aborted; i++)
        begin
            next_edge();
            lcg_state = lcg_next(lcg_state);
            gap = lcg_state[19] ? 0 : int'(lcg_state[17:16]);   // Mostly back to back
            if (no_gap[i])
                gap = 0;   // Producer still in the pipe, stalls pile up
            repeat (gap) next_edge();
            waited = 0;
            while (credits == 0 && waited < TIMEOUT)
            begin
                next_edge();
                waited++;
            end
            if (credits == 0)
            begin
                wb_check.report_error($sformatf("no credit returned before %s", names[i]));
                aborted = 1'b1;
            end
            else
            begin
                instr_valid <= 1'b1;
                instr       <= instrs[i];
                credits--;
                if (expects[i].valid)
                    wb_check.expect_write(names[i], expects[i]);
                else
                    $display("Sent %s, no write-back expected", names[i]);
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (wb_check.pending() != 0 && waited < TIMEOUT)
        begin
            next_edge();
            @(negedge clk);   // Checker done with this edge
            waited++;
        end
        if (wb_check.pending() != 0)
        begin
            wb_check.report_error($sformatf("%0d expected writes never arrived",
                                            wb_check.pending()));
            aborted = 1'b1;
        end
    endtask

    task automatic wait_credits();
        int waited;
        waited = 0;
        while (credits != `ARM_BUF_DEPTH && waited < TIMEOUT)
        begin
            next_edge();
            waited++;
        end
        if (credits != `ARM_BUF_DEPTH)
            wb_check.report_error($sformatf("only %0d credits came back", credits));
    endtask

    task automatic finish_run();
        @(negedge clk);
        wb_check.print_totals();
        if (wb_check.fail_count == 0 && wb_check.error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    endtask

    initial
    begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        aborted     = 1'b0;
        credits     = `ARM_BUF_DEPTH;
        lcg_state   = 32'hf8f4;

        // Registers from reset, then plain ALU chain with forwarding
        no_gap_now = 1'b1;   // EX, MEM and WB forwarding need back-to-back issue
        add_row("mov_reads_reset_r1", dp_reg(AL, OP_MOV, 0, 0, 2, 1), 1, 2, 32'h0);
        add_row("mov_imm_r1", dp_imm(AL, OP_MOV, 0, 0, 1, 'h25), 1, 1, 32'h25);
        add_row("add_imm_fwd", dp_imm(AL, OP_ADD, 0, 1, 3, 'h10), 1, 3, 32'h35);
        add_row("sub_reg_fwd", dp_reg(AL, OP_SUB, 0, 3, 4, 1), 1, 4, 32'h10);
        add_row("rsb_imm", dp_imm(AL, OP_RSB, 0, 4, 5, 'h30), 1, 5, 32'h20);
        add_row("and_reg", dp_reg(AL, OP_AND, 0, 3, 6, 5), 1, 6, 32'h20);
        add_row("eor_imm", dp_imm(AL, OP_EOR, 0, 3, 7, 'hFF), 1, 7, 32'hCA);
        add_row("orr_reg", dp_reg(AL, OP_ORR, 0, 7, 8, 4), 1, 8, 32'hDA);
        add_row("bic_imm", dp_imm(AL, OP_BIC, 0, 8, 9, 'h0F), 1, 9, 32'hD0);
        add_row("mvn_imm", dp_imm(AL, OP_MVN, 0, 0, 10, 'h00), 1, 10, 32'hFFFF_FFFF);
        add_row("add_reg_wrap", dp_reg(AL, OP_ADD, 0, 10, 11, 1), 1, 11, 32'h24);

        // 0x25 - 0x35 gives N set, C clear
        no_gap_now = 1'b0;   // Random sender gaps from here
        add_row("cmp_negative", dp_reg(AL, OP_CMP, 1, 1, 0, 3), 0, 0, 32'h0);
        add_row("movlt_taken", dp_imm('hB, OP_MOV, 0, 0, 12, 'h01), 1, 12, 32'h1);
        add_row("movge_skipped", dp_imm('hA, OP_MOV, 0, 0, 12, 'h02), 0, 0, 32'h0);
        add_row("movne_taken", dp_imm('h1, OP_MOV, 0, 0, 13, 'h03), 1, 13, 32'h3);
        add_row("moveq_skipped", dp_imm('h0, OP_MOV, 0, 0, 13, 'h04), 0, 0, 32'h0);
        add_row("movcc_taken", dp_imm('h3, OP_MOV, 0, 0, 14, 'h05), 1, 14, 32'h5);
        add_row("movhi_skipped", dp_imm('h8, OP_MOV, 0, 0, 14, 'h06), 0, 0, 32'h0);
        add_row("movnv_never", dp_imm('hF, OP_MOV, 0, 0, 14, 'h07), 0, 0, 32'h0);

        // Zero result, Z and C set
        add_row("subs_zero_r15", dp_reg(AL, OP_SUB, 1, 3, 15, 3), 1, 15, 32'h0);
        add_row("moveq_taken", dp_imm('h0, OP_MOV, 0, 0, 12, 'h08), 1, 12, 32'h8);
        add_row("movgt_skipped", dp_imm('hC, OP_MOV, 0, 0, 12, 'h09), 0, 0, 32'h0);
        add_row("movle_taken", dp_imm('hD, OP_MOV, 0, 0, 13, 'h0A), 1, 13, 32'hA);
        add_row("movcs_taken", dp_imm('h2, OP_MOV, 0, 0, 13, 'h0B), 1, 13, 32'hB);
        add_row("mvnsne_skipped", dp_imm('h1, OP_MVN, 1, 0, 14, 'h00), 0, 0, 32'h0);
        add_row("moveq_flags_kept", dp_imm('h0, OP_MOV, 0, 0, 14, 'h0C), 1, 14, 32'hC);

        // 0x25 - 0x10, all flags clear but C
        add_row("cmp_positive", dp_imm(AL, OP_CMP, 1, 1, 0, 'h10), 0, 0, 32'h0);
        add_row("movgt_taken", dp_imm('hC, OP_MOV, 0, 0, 12, 'h0D), 1, 12, 32'hD);
        add_row("movls_skipped", dp_imm('h9, OP_MOV, 0, 0, 12, 'h0E), 0, 0, 32'h0);
        add_row("movvc_taken", dp_imm('h7, OP_MOV, 0, 0, 11, 'h0F), 1, 11, 32'hF);

        // Data RAM, word 8 then word 48 via base 0xCA minus 0xA
        no_gap_now = 1'b1;   // Load-use stalls use up every credit
        add_row("str_pos_offset", ldst(0, 1, 0, 3, 'h020), 0, 0, 32'h0);
        add_row("ldr_pos_offset", ldst(1, 1, 0, 5, 'h020), 1, 5, 32'h35);
        add_row("add_after_load", dp_reg(AL, OP_ADD, 0, 5, 6, 5), 1, 6, 32'h6A);
        add_row("str_neg_offset", ldst(0, 0, 7, 8, 'h00A), 0, 0, 32'h0);
        add_row("ldr_neg_offset", ldst(1, 0, 7, 9, 'h00A), 1, 9, 32'hDA);
        add_row("add_imm_after_load", dp_imm(AL, OP_ADD, 0, 9, 10, 'h01), 1, 10, 32'hDB);

        // Branch retires as nothing
        add_row("branch_no_write", 32'hEA00_0010, 0, 0, 32'h0);
        add_row("mov_after_branch", dp_imm(AL, OP_MOV, 0, 0, 1, 'h42), 1, 1, 32'h42);
        add_row("cmp_no_write", dp_reg(AL, OP_CMP, 1, 1, 0, 10), 0, 0, 32'h0);
        add_row("eor_after_cmp", dp_reg(AL, OP_EOR, 0, 1, 2, 6), 1, 2, 32'h28);   // Last row writes

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        send_all();
        if (!aborted)
            wait_drain();
        if (!aborted)
            wait_credits();
        finish_run();
    end

endmodule

//--- dv/wb_checker.sv
`include "arm_settings.svh"

module wb_checker (
    input  logic         clk,
    input  logic         rst,
    input  logic         instr_valid,
    input  logic         credit,
    input  arm_pkg::wb_t wb
);

    string        exp_names [$];    // Test names in write order
    arm_pkg::wb_t exp_writes [$];   // Expected rd and data, same order
    int           pass_count;
    int           fail_count;       // Value mismatches
    int           error_count;      // Everything else
    int           credits;          // Sender credits as seen on the wires

    initial
    begin
        pass_count  = 0;
        fail_count  = 0;
        error_count = 0;
        credits     = `ARM_BUF_DEPTH;
    end

    task automatic expect_write(input string name, input arm_pkg::wb_t exp);
        exp_names.push_back(name);
        exp_writes.push_back(exp);
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        error_count++;
    endtask

    function automatic int pending();
        return exp_writes.size();
    endfunction

    task automatic print_totals();
        $display("Totals: %0d passed, %0d mismatched, %0d other errors",
                 pass_count, fail_count, error_count);
    endtask

    // Everything sampled as it stood before the edge
    always @(posedge clk)
    begin
        string        name;
        arm_pkg::wb_t exp;
        if (rst)
        begin
            credits = `ARM_BUF_DEPTH;   // Full credit again after reset
        end
        else
        begin
            credits = credits + int'(credit) - int'(instr_valid);
            if (credits < 0 || credits > `ARM_BUF_DEPTH)
                report_error($sformatf("credit count left its range, now %0d", credits));
            if (wb.valid === 1'b1)
            begin
                if (exp_writes.size() == 0)
                begin
                    report_error($sformatf("unexpected register write R%0d=%08h",
                                           wb.rd, wb.data));
                end
                else
                begin
                    name = exp_names.pop_front();
                    exp  = exp_writes.pop_front();
                    if (wb.rd !== exp.rd || wb.data !== exp.data)
                    begin
                        $display("Mismatch %s expected R%0d=%08h actual R%0d=%08h",
                                 name, exp.rd, exp.data, wb.rd, wb.data);
                        fail_count++;
                    end
                    else
                    begin
                        $display("Pass %s R%0d=%08h", name, wb.rd, wb.data);
                        pass_count++;
                    end
                end
            end
        end
    end

endmodule

//--- hw/arm_pipeline.sv
module arm_pipeline (
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  arm_pkg::instr_t instr,
    output logic            credit,
    output arm_pkg::wb_t    wb
);

    arm_pkg::instr_t   head;
    logic              not_empty;
    logic              pop;
    arm_pkg::reg_idx_t rd_a, rd_b, rd_c;
    arm_pkg::word_t    data_a, data_b, data_c;
    arm_pkg::id_ex_t   id_ex;
    arm_pkg::word_t    ex_result;    // Combinational ALU output
    arm_pkg::ex_mem_t  ex_mem;

    instr_buffer u_instr_buffer (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pop         (pop),
        .head        (head),
        .not_empty   (not_empty),
        .credit      (credit)
    );

    register_file u_register_file (
        .clk    (clk),
        .rst    (rst),
        .rd_a   (rd_a),
        .rd_b   (rd_b),
        .rd_c   (rd_c),
        .data_a (data_a),
        .data_b (data_b),
        .data_c (data_c),
        .wb     (wb)
    );

    // EX/MEM register seen both as execute output and as MEM occupant
    decode_stage u_decode_stage (
        .clk       (clk),
        .rst       (rst),
        .head      (head),
        .not_empty (not_empty),
        .pop       (pop),
        .rd_a      (rd_a),
        .rd_b      (rd_b),
        .rd_c      (rd_c),
        .data_a    (data_a),
        .data_b    (data_b),
        .data_c    (data_c),
        .ex_fwd    (ex_mem),
        .ex_result (ex_result),
        .ex_ctrl   (id_ex),
        .mem_fwd   (ex_mem),
        .wb_fwd    (wb),
        .id_ex     (id_ex)
    );

    execute_stage u_execute_stage (
        .clk    (clk),
        .rst    (rst),
        .id_ex  (id_ex),
        .result (ex_result),
        .ex_mem (ex_mem)
    );

    memory_stage u_memory_stage (
        .clk    (clk),
        .rst    (rst),
        .ex_mem (ex_mem),
        .wb     (wb)
    );

endmodule

//--- hw/arm_pkg.sv
`include "arm_settings.svh"

package arm_pkg;

    typedef logic [`ARM_DATA_W-1:0] word_t;                  // Data word
    typedef logic [`ARM_DATA_W-1:0] instr_t;                 // Raw instruction
    typedef logic [$clog2(`ARM_REG_COUNT)-1:0] reg_idx_t;    // Register index
    typedef logic [3:0] cond_t;                              // Bits 31:28
    typedef logic [3:0] flags_t;                             // N Z C V, N in bit 3

    // Condition codes with special handling
    localparam cond_t COND_AL = 4'b1110;   // Always
    localparam cond_t COND_NV = 4'b1111;   // Never executes

    // Data processing opcodes, bits 24:21
    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_EOR = 4'b0001,
        ALU_SUB = 4'b0010,
        ALU_RSB = 4'b0011,
        ALU_ADD = 4'b0100,
        ALU_CMP = 4'b1010,
        ALU_ORR = 4'b1100,
        ALU_MOV = 4'b1101,
        ALU_BIC = 4'b1110,
        ALU_MVN = 4'b1111
    } alu_op_t;

    typedef enum logic [1:0] {
        CLS_DATA_IMM,      // 001
        CLS_DATA_REG,      // 000, shift field ignored
        CLS_LDST_IMM,      // 010
        CLS_UNSUPPORTED    // Retires as a no-op
    } instr_class_t;

    // Operand source in decode
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    typedef struct packed {
        logic    valid;
        alu_op_t alu_op;
        logic    use_imm;       // Second operand from imm instead of b
        logic    set_flags;
        logic    writes_reg;
        logic    is_load;
        logic    is_store;
        cond_t   cond;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    a;            // Rn
        word_t    b;            // Rm
        word_t    store_data;   // Rd for stores
        reg_idx_t rd;
        word_t    imm;          // Zero-extended imm8 or offset12
    } id_ex_t;

    typedef struct packed {
        logic     valid;        // Condition already resolved
        logic     writes_reg;
        logic     is_load;
        logic     is_store;
        reg_idx_t rd;
        word_t    result;       // ALU result or effective address
        word_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;        // Only set for real register writes
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

//--- hw/decode_stage.sv
module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  arm_pkg::instr_t   head,
    input  logic              not_empty,
    output logic              pop,
    output arm_pkg::reg_idx_t rd_a,
    output arm_pkg::reg_idx_t rd_b,
    output arm_pkg::reg_idx_t rd_c,
    input  arm_pkg::word_t    data_a,
    input  arm_pkg::word_t    data_b,
    input  arm_pkg::word_t    data_c,
    input  arm_pkg::ex_mem_t  ex_fwd,
    input  arm_pkg::word_t    ex_result,
    input  arm_pkg::id_ex_t   ex_ctrl,
    input  arm_pkg::ex_mem_t  mem_fwd,
    input  arm_pkg::wb_t      wb_fwd,
    output arm_pkg::id_ex_t   id_ex
);

    arm_pkg::instr_class_t cls;
    arm_pkg::ctrl_t        ctrl;
    arm_pkg::word_t        imm;
    arm_pkg::fwd_sel_t     sel_a, sel_b, sel_c;
    arm_pkg::id_ex_t       next;
    logic                  uses_a, uses_b, uses_c;
    logic                  ex_late;      // EX value not safe to forward yet
    logic                  stall;

    // Youngest writer of idx wins
    function automatic arm_pkg::fwd_sel_t pick_src(input arm_pkg::reg_idx_t idx);
        if (ex_ctrl.ctrl.valid && ex_ctrl.ctrl.writes_reg && ex_ctrl.rd == idx)
            return arm_pkg::FWD_EX;
        if (mem_fwd.valid && mem_fwd.writes_reg && mem_fwd.rd == idx)
            return arm_pkg::FWD_MEM;
        if (wb_fwd.valid && wb_fwd.rd == idx)
            return arm_pkg::FWD_WB;
        return arm_pkg::FWD_RF;
    endfunction

    function automatic arm_pkg::word_t fwd_value(input arm_pkg::fwd_sel_t sel,
                                                 input arm_pkg::word_t rf_word);
        case (sel)
            arm_pkg::FWD_EX:  return ex_result;
            arm_pkg::FWD_MEM: return mem_fwd.result;
            arm_pkg::FWD_WB:  return wb_fwd.data;
            default:          return rf_word;
        endcase
    endfunction

    always_comb
    begin
        ctrl   = '0;
        imm    = '0;
        uses_a = 1'b0;
        uses_b = 1'b0;
        uses_c = 1'b0;
        ctrl.cond = head[31:28];
        case (head[27:25])
            3'b000:  cls = arm_pkg::CLS_DATA_REG;
            3'b001:  cls = arm_pkg::CLS_DATA_IMM;
            3'b010:  cls = arm_pkg::CLS_LDST_IMM;
            default: cls = arm_pkg::CLS_UNSUPPORTED;   // Branches and the rest
        endcase
        case (cls)
            arm_pkg::CLS_DATA_REG, arm_pkg::CLS_DATA_IMM:
            begin
                ctrl.alu_op = arm_pkg::alu_op_t'(head[24:21]);
                case (head[24:21])   // Only the kept opcodes are valid
                    4'b0000, 4'b0001, 4'b0010, 4'b0011, 4'b0100,
                    4'b1010, 4'b1100, 4'b1101, 4'b1110, 4'b1111: ctrl.valid = 1'b1;
                    default: ctrl.valid = 1'b0;
                endcase
                ctrl.use_imm    = (cls == arm_pkg::CLS_DATA_IMM);
                ctrl.set_flags  = head[20] || (ctrl.alu_op == arm_pkg::ALU_CMP);
                ctrl.writes_reg = (ctrl.alu_op != arm_pkg::ALU_CMP);
                imm    = arm_pkg::word_t'(head[7:0]);   // Rotate ignored
                uses_a = (ctrl.alu_op != arm_pkg::ALU_MOV) && (ctrl.alu_op != arm_pkg::ALU_MVN);
                uses_b = (cls == arm_pkg::CLS_DATA_REG);
            end
            arm_pkg::CLS_LDST_IMM:
            begin
                ctrl.valid      = 1'b1;
                ctrl.alu_op     = head[23] ? arm_pkg::ALU_ADD : arm_pkg::ALU_SUB;   // U bit
                ctrl.use_imm    = 1'b1;
                ctrl.is_load    = head[20];
                ctrl.is_store   = !head[20];
                ctrl.writes_reg = head[20];
                imm    = arm_pkg::word_t'(head[11:0]);
                uses_a = 1'b1;         // Base
                uses_c = !head[20];    // Store data
            end
            default: ;
        endcase
        if (ctrl.cond == arm_pkg::COND_NV)
            ctrl.valid = 1'b0;
    end

    assign rd_a = head[19:16];
    assign rd_b = head[3:0];
    assign rd_c = head[15:12];

    always_comb
    begin
        sel_a = pick_src(rd_a);   // Rn source
        sel_b = pick_src(rd_b);   // Rm source
        sel_c = pick_src(rd_c);   // Store data source
    end

    // Load data not back yet, or condition still open in EX
    assign ex_late = ex_ctrl.ctrl.is_load || (ex_ctrl.ctrl.cond != arm_pkg::COND_AL);

    always_comb
    begin
        stall = 1'b0;
        if (uses_a && ((sel_a == arm_pkg::FWD_EX && ex_late) ||
                       (sel_a == arm_pkg::FWD_MEM && ex_fwd.is_load)))
            stall = 1'b1;
        if (uses_b && ((sel_b == arm_pkg::FWD_EX && ex_late) ||
                       (sel_b == arm_pkg::FWD_MEM && ex_fwd.is_load)))
            stall = 1'b1;
        if (uses_c && ((sel_c == arm_pkg::FWD_EX && ex_late) ||
                       (sel_c == arm_pkg::FWD_MEM && ex_fwd.is_load)))
            stall = 1'b1;
        stall = stall && not_empty && ctrl.valid;
    end

    assign pop = not_empty && !stall;

    always_comb
    begin
        next            = '0;
        next.ctrl       = ctrl;
        next.ctrl.valid = ctrl.valid && pop;   // Bubble on stall or empty
        next.a          = fwd_value(sel_a, data_a);
        next.b          = fwd_value(sel_b, data_b);
        next.store_data = fwd_value(sel_c, data_c);
        next.rd         = head[15:12];
        next.imm        = imm;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            id_ex.ctrl.valid <= 1'b0;
        else
            id_ex <= next;
    end

endmodule

//--- hw/execute_stage.sv
module execute_stage (
    input  logic             clk,
    input  logic             rst,
    input  arm_pkg::id_ex_t  id_ex,
    output arm_pkg::word_t   result,
    output arm_pkg::ex_mem_t ex_mem
);

    localparam int W = $bits(arm_pkg::word_t);

    arm_pkg::flags_t flags;       // Status register
    arm_pkg::flags_t new_flags;
    arm_pkg::word_t  op_b;
    arm_pkg::word_t  add_x, add_y;
    logic            add_cin;
    logic [W:0]      sum;         // Carry in top bit
    logic            is_arith;
    logic            pass;
    logic            exec;

    function automatic logic cond_pass(input arm_pkg::cond_t cond, input arm_pkg::flags_t f);
        logic n, z, c, v;
        n = f[3];
        z = f[2];
        c = f[1];
        v = f[0];
        case (cond)
            4'b0000: return z;                  // EQ
            4'b0001: return !z;                 // NE
            4'b0010: return c;                  // CS
            4'b0011: return !c;                 // CC
            4'b0100: return n;                  // MI
            4'b0101: return !n;                 // PL
            4'b0110: return v;                  // VS
            4'b0111: return !v;                 // VC
            4'b1000: return c && !z;            // HI
            4'b1001: return !c || z;            // LS
            4'b1010: return n == v;             // GE
            4'b1011: return n != v;             // LT
            4'b1100: return !z && (n == v);     // GT
            4'b1101: return z || (n != v);      // LE
            4'b1110: return 1'b1;               // AL
            default: return 1'b0;               // 1111 never
        endcase
    endfunction

    assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.b;

    // One adder, subtraction as x + ~y + 1
    always_comb
    begin
        add_x   = id_ex.a;
        add_y   = op_b;
        add_cin = 1'b0;
        case (id_ex.ctrl.alu_op)
            arm_pkg::ALU_SUB, arm_pkg::ALU_CMP:
            begin
                add_y   = ~op_b;
                add_cin = 1'b1;
            end
            arm_pkg::ALU_RSB:
            begin
                add_x   = op_b;         // Reverse, op_b - a
                add_y   = ~id_ex.a;
                add_cin = 1'b1;
            end
            default: ;
        endcase
        sum = {1'b0, add_x} + {1'b0, add_y} + add_cin;
    end

    always_comb
    begin
        is_arith = 1'b0;
        case (id_ex.ctrl.alu_op)
            arm_pkg::ALU_AND: result = id_ex.a & op_b;
            arm_pkg::ALU_EOR: result = id_ex.a ^ op_b;
            arm_pkg::ALU_ORR: result = id_ex.a | op_b;
            arm_pkg::ALU_MOV: result = op_b;
            arm_pkg::ALU_BIC: result = id_ex.a & ~op_b;
            arm_pkg::ALU_MVN: result = ~op_b;
            default:
            begin
                result   = sum[W-1:0];   // ADD SUB RSB CMP, also load/store address
                is_arith = 1'b1;
            end
        endcase
    end

    // Logic ops keep C and V
    assign new_flags[3] = result[W-1];
    assign new_flags[2] = (result == '0);
    assign new_flags[1] = is_arith ? sum[W] : flags[1];
    assign new_flags[0] = is_arith ? (add_x[W-1] == add_y[W-1]) && (sum[W-1] != add_x[W-1])
                                   : flags[0];

    assign pass = cond_pass(id_ex.ctrl.cond, flags);
    assign exec = id_ex.ctrl.valid && pass;   // Failed condition becomes a bubble

    always_ff @(posedge clk)
    begin
        if (rst)
            flags <= '0;
        else if (exec && id_ex.ctrl.set_flags)
            flags <= new_flags;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ex_mem.valid <= 1'b0;
        end
        else
        begin
            ex_mem.valid      <= exec;
            ex_mem.writes_reg <= id_ex.ctrl.writes_reg;
            ex_mem.is_load    <= id_ex.ctrl.is_load;
            ex_mem.is_store   <= id_ex.ctrl.is_store;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.result     <= result;
            ex_mem.store_data <= id_ex.store_data;
        end
    end

endmodule

//--- hw/instr_buffer.sv
`include "arm_settings.svh"

module instr_buffer (
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  arm_pkg::instr_t instr,
    input  logic            pop,
    output arm_pkg::instr_t head,
    output logic            not_empty,
    output logic            credit
);

    localparam int PTR_W = $clog2(`ARM_BUF_DEPTH);
    localparam int CNT_W = $clog2(`ARM_BUF_DEPTH + 1);

    arm_pkg::instr_t mem [`ARM_BUF_DEPTH];   // Entry storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Sender holds a credit per free slot, no full check needed
    always_ff @(posedge clk)
    begin
        if (instr_valid)
            mem[wr_ptr] <= instr;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end
        else
        begin
            if (instr_valid)
                wr_ptr <= (wr_ptr == PTR_W'(`ARM_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(`ARM_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count  <= count + CNT_W'(instr_valid) - CNT_W'(pop);   // Push and pop may coincide
            credit <= pop;   // Freed slot goes back one cycle later
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

//--- hw/memory_stage.sv
`include "arm_settings.svh"

module memory_stage (
    input  logic             clk,
    input  logic             rst,
    input  arm_pkg::ex_mem_t ex_mem,
    output arm_pkg::wb_t     wb
);

    localparam int ADDR_W = $clog2(`ARM_DMEM_WORDS);

    arm_pkg::word_t    ram [`ARM_DMEM_WORDS];   // Left uninitialized
    logic [ADDR_W-1:0] addr;
    arm_pkg::word_t    rd_word;

    // Word address, byte offset bits dropped
    assign addr    = ex_mem.result[ADDR_W+1:2];
    assign rd_word = ram[addr];   // Async read for loads

    always_ff @(posedge clk)
    begin
        if (ex_mem.valid && ex_mem.is_store)
            ram[addr] <= ex_mem.store_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb.valid <= 1'b0;
        end
        else
        begin
            wb.valid <= ex_mem.valid && ex_mem.writes_reg;   // Stores and CMP drop out here
            wb.rd    <= ex_mem.rd;
            wb.data  <= ex_mem.is_load ? rd_word : ex_mem.result;
        end
    end

endmodule

//--- hw/register_file.sv
`include "arm_settings.svh"

module register_file (
    input  logic              clk,
    input  logic              rst,
    input  arm_pkg::reg_idx_t rd_a,
    input  arm_pkg::reg_idx_t rd_b,
    input  arm_pkg::reg_idx_t rd_c,
    output arm_pkg::word_t    data_a,
    output arm_pkg::word_t    data_b,
    output arm_pkg::word_t    data_c,
    input  arm_pkg::wb_t      wb
);

    arm_pkg::word_t regs [`ARM_REG_COUNT];

    // Architectural state starts at zero
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `ARM_REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wb.valid)
        begin
            regs[wb.rd] <= wb.data;   // Write at end of WB
        end
    end

    // Old value during the write cycle, decode forwards from WB
    assign data_a = regs[rd_a];   // Rn
    assign data_b = regs[rd_b];   // Rm
    assign data_c = regs[rd_c];   // Rd, store data

endmodule

//--- include/arm_settings.svh
`ifndef ARM_SETTINGS_SVH
`define ARM_SETTINGS_SVH

// Datapath and instruction width
`define ARM_DATA_W 32

// Architectural registers, R0 to R15
// R15 is a plain register here, no PC behind it
`define ARM_REG_COUNT 16

// Instruction buffer entries
// Also the credit count the sender starts with after reset
`define ARM_BUF_DEPTH 4

// Data RAM size in 32-bit words
// Word address comes from bits 7:2 of the effective address
`define ARM_DMEM_WORDS 64

`endif

//--- sim.f
+incdir+include
hw/arm_pkg.sv
hw/instr_buffer.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/arm_pipeline.sv
dv/wb_checker.sv
dv/tb_arm_pipeline.sv
